/* include/issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// data and pc width
`define ISSUE_XLEN 32

// register address width
`define ISSUE_REGADDR_W 5

// multiply latency, issue to request
`define ISSUE_MUL_CYCLES 4

// data memory depth in words
`define ISSUE_DMEM_WORDS 64

`endif

/* logic/issue_pkg.sv */
`include "issue_config.svh"

package issue_pkg;

    typedef logic [`ISSUE_REGADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_XLEN-1:0]      xword_t;

    typedef enum logic [2:0] {
        op_alu,
        op_mul,
        op_load,
        op_store,
        op_jump
    } op_class_t;

    typedef enum logic [1:0] {
        fn_add,
        fn_sub,
        fn_and,
        fn_or
    } alu_fn_t;

    // one decoded slot, operands already read
    typedef struct packed {
        logic      valid;
        xword_t    pc;
        op_class_t op_class;
        alu_fn_t   fn;
        reg_addr_t rs1;
        logic      rs1_en;
        reg_addr_t rs2;
        logic      rs2_en;
        reg_addr_t rd;
        logic      rd_en;
        xword_t    opa;
        xword_t    opb;
    } issue_slot_t;

    // bit 0 int0, bit 1 int1, bit 2 mem
    typedef logic [2:0] unit_sel_t;

    typedef struct packed {
        logic      busy;
        reg_addr_t rd;
        logic      rd_en;
    } unit_status_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xword_t    data;
    } wb_t;

endpackage

/* logic/issue_scoreboard.sv */
`timescale 1ns/100ps

module issue_scoreboard (
    input  issue_pkg::issue_slot_t  slot1,
    input  issue_pkg::issue_slot_t  slot2,
    input  issue_pkg::unit_status_t st_int0,
    input  issue_pkg::unit_status_t st_int1,
    input  issue_pkg::unit_status_t st_mem,
    output logic                    stall1,
    output logic                    stall2,
    output logic                    flush2,
    output issue_pkg::issue_slot_t  issue_int0,
    output issue_pkg::issue_slot_t  issue_int1,
    output issue_pkg::issue_slot_t  issue_mem
);
    import issue_pkg::*;

    unit_sel_t free;
    unit_sel_t free2;
    unit_sel_t sel1;
    unit_sel_t sel2;
    logic      hit1;
    logic      hit2;
    logic      pair_dep;
    logic      go1;
    logic      go2;

    // raw or waw against one busy unit
    function automatic logic busy_hit(issue_slot_t s, unit_status_t st);
        logic src;
        logic dst;
        src = (s.rs1_en && s.rs1 == st.rd) || (s.rs2_en && s.rs2 == st.rd);
        dst = s.rd_en && s.rd == st.rd;
        return st.busy && st.rd_en && (src || dst);
    endfunction

    // first free unit of the kind the slot needs, int0 before int1
    function automatic unit_sel_t pick(issue_slot_t s, unit_sel_t avail);
        unit_sel_t sel;
        sel = '0;
        if (s.op_class == op_load || s.op_class == op_store) begin
            if (avail[2]) begin
                sel = 3'b100;
            end
        end else if (avail[0]) begin
            sel = 3'b001;
        end else if (avail[1]) begin
            sel = 3'b010;
        end
        return sel;
    endfunction

    assign free = ~{st_mem.busy, st_int1.busy, st_int0.busy};

    assign hit1 = busy_hit(slot1, st_int0) || busy_hit(slot1, st_int1) ||
                  busy_hit(slot1, st_mem);
    assign hit2 = busy_hit(slot2, st_int0) || busy_hit(slot2, st_int1) ||
                  busy_hit(slot2, st_mem);

    assign sel1   = pick(slot1, free);
    assign stall1 = slot1.valid && (hit1 || sel1 == '0);
    assign go1    = slot1.valid && !stall1;
    assign flush2 = go1 && slot1.op_class == op_jump;

    // slot 2 only gets what slot 1 leaves
    assign free2 = free & ~(sel1 & {3{go1}});
    assign sel2  = pick(slot2, free2);

    // in-pair dependency on the older slot's destination
    assign pair_dep = slot1.valid && slot1.rd_en &&
                      ((slot2.rs1_en && slot2.rs1 == slot1.rd) ||
                       (slot2.rs2_en && slot2.rs2 == slot1.rd) ||
                       (slot2.rd_en && slot2.rd == slot1.rd));

    assign stall2 = slot2.valid &&
                    ((slot1.valid && stall1) || hit2 || pair_dep || sel2 == '0);
    assign go2    = slot2.valid && !stall2 && !flush2;

    always_comb begin
        issue_int0 = '0;
        issue_int1 = '0;
        issue_mem  = '0;
        if (go2) begin
            case (sel2)
                3'b001:  issue_int0 = slot2;
                3'b010:  issue_int1 = slot2;
                3'b100:  issue_mem  = slot2;
                default: ;
            endcase
        end
        if (go1) begin
            case (sel1)
                3'b001:  issue_int0 = slot1;
                3'b010:  issue_int1 = slot1;
                3'b100:  issue_mem  = slot1;
                default: ;
            endcase
        end
    end

endmodule

/* logic/int_unit.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module int_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  issue_pkg::issue_slot_t  issue,
    input  logic                    grant,
    output issue_pkg::unit_status_t status,
    output logic                    req,
    output issue_pkg::wb_t          result
);
    import issue_pkg::*;

    localparam int CNT_W = $clog2(`ISSUE_MUL_CYCLES);

    typedef enum logic [1:0] {idle, mul_wait, pending} state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    reg_addr_t        rd;
    logic             rd_en;
    xword_t           data;
    xword_t           alu_out;

    always_comb begin
        case (issue.fn)
            fn_add:  alu_out = issue.opa + issue.opb;
            fn_sub:  alu_out = issue.opa - issue.opb;
            fn_and:  alu_out = issue.opa & issue.opb;
            default: alu_out = issue.opa | issue.opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (issue.valid && issue.op_class == op_mul) begin
                        state <= mul_wait;
                        cnt   <= CNT_W'(`ISSUE_MUL_CYCLES - 2);
                    end else if (issue.valid && issue.rd_en) begin
                        state <= pending;
                    end
                end
                mul_wait: begin
                    if (cnt == '0) begin
                        state <= rd_en ? pending : idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                pending: begin
                    // result stays on the bus request until taken
                    if (grant) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && issue.valid) begin
            rd    <= issue.rd;
            rd_en <= issue.rd_en;
            case (issue.op_class)
                op_mul:  data <= issue.opa * issue.opb;
                op_jump: data <= issue.pc + xword_t'(4);
                default: data <= alu_out;
            endcase
        end
    end

    assign req    = state == pending;
    assign status = '{busy: state != idle, rd: rd, rd_en: rd_en};
    assign result = '{valid: req, rd: rd, data: data};

endmodule

/* logic/mem_unit.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module mem_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  issue_pkg::issue_slot_t  issue,
    input  logic                    grant,
    output issue_pkg::unit_status_t status,
    output logic                    req,
    output issue_pkg::wb_t          result
);
    import issue_pkg::*;

    localparam int IDX_W = $clog2(`ISSUE_DMEM_WORDS);

    typedef enum logic [1:0] {idle, st_busy, ld_pending} state_t;

    state_t           state;
    xword_t           mem [`ISSUE_DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             is_load;
    reg_addr_t        rd;
    logic             rd_en;
    xword_t           data;

    // word address, wraps at memory depth
    assign idx     = issue.opa[IDX_W+1:2];
    assign is_load = issue.op_class == op_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            for (int i = 0; i < `ISSUE_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                idle: begin
                    if (issue.valid) begin
                        state <= (is_load && issue.rd_en) ? ld_pending : st_busy;
                    end
                    if (issue.valid && issue.op_class == op_store) begin
                        mem[idx] <= issue.opb;
                    end
                end
                st_busy:    state <= idle;
                ld_pending: begin
                    if (grant) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && issue.valid) begin
            rd    <= issue.rd;
            rd_en <= is_load && issue.rd_en;
            data  <= mem[idx];
        end
    end

    assign req    = state == ld_pending;
    assign status = '{busy: state != idle, rd: rd, rd_en: rd_en};
    assign result = '{valid: req, rd: rd, data: data};

endmodule

/* logic/wb_arbiter.sv */
`timescale 1ns/100ps

module wb_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           req_mem,
    input  logic           req_int0,
    input  logic           req_int1,
    input  issue_pkg::wb_t res_mem,
    input  issue_pkg::wb_t res_int0,
    input  issue_pkg::wb_t res_int1,
    output logic           grant_mem,
    output logic           grant_int0,
    output logic           grant_int1,
    output issue_pkg::wb_t wb
);
    import issue_pkg::*;

    unit_sel_t gnt;
    wb_t       granted;

    // mem over int0 over int1
    assign gnt[2] = req_mem;
    assign gnt[0] = req_int0 && !req_mem;
    assign gnt[1] = req_int1 && !req_mem && !req_int0;

    assign grant_mem  = gnt[2];
    assign grant_int0 = gnt[0];
    assign grant_int1 = gnt[1];

    always_comb begin
        case (gnt)
            3'b100:  granted = res_mem;
            3'b001:  granted = res_int0;
            default: granted = res_int1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= |gnt;
            wb.rd    <= granted.rd;
            wb.data  <= granted.data;
        end
    end

endmodule

/* logic/issue_top.sv */
`timescale 1ns/100ps

module issue_top (
    input  logic                   clk,
    input  logic                   rst,
    input  issue_pkg::issue_slot_t slot1,
    input  issue_pkg::issue_slot_t slot2,
    output logic                   stall1,
    output logic                   stall2,
    output logic                   flush2,
    output issue_pkg::wb_t         wb
);
    import issue_pkg::*;

    issue_slot_t  issue_int0;
    issue_slot_t  issue_int1;
    issue_slot_t  issue_mem;
    unit_status_t st_int0;
    unit_status_t st_int1;
    unit_status_t st_mem;
    logic         req_int0;
    logic         req_int1;
    logic         req_mem;
    logic         grant_int0;
    logic         grant_int1;
    logic         grant_mem;
    wb_t          res_int0;
    wb_t          res_int1;
    wb_t          res_mem;

    issue_scoreboard u_scoreboard (
        .slot1      (slot1),
        .slot2      (slot2),
        .st_int0    (st_int0),
        .st_int1    (st_int1),
        .st_mem     (st_mem),
        .stall1     (stall1),
        .stall2     (stall2),
        .flush2     (flush2),
        .issue_int0 (issue_int0),
        .issue_int1 (issue_int1),
        .issue_mem  (issue_mem)
    );

    int_unit u_int0 (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue_int0),
        .grant  (grant_int0),
        .status (st_int0),
        .req    (req_int0),
        .result (res_int0)
    );

    int_unit u_int1 (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue_int1),
        .grant  (grant_int1),
        .status (st_int1),
        .req    (req_int1),
        .result (res_int1)
    );

    mem_unit u_mem (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue_mem),
        .grant  (grant_mem),
        .status (st_mem),
        .req    (req_mem),
        .result (res_mem)
    );

    wb_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req_mem    (req_mem),
        .req_int0   (req_int0),
        .req_int1   (req_int1),
        .res_mem    (res_mem),
        .res_int0   (res_int0),
        .res_int1   (res_int1),
        .grant_mem  (grant_mem),
        .grant_int0 (grant_int0),
        .grant_int1 (grant_int1),
        .wb         (wb)
    );

endmodule

/* testbench/tb_issue_top.sv */
`timescale 1ns/100ps
`include "issue_config.svh"

module tb_issue_top;
    import issue_pkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam int NREGS      = 1 << `ISSUE_REGADDR_W;

    logic        clk;
    logic        rst;
    issue_slot_t slot1;
    issue_slot_t slot2;
    logic        stall1;
    logic        stall2;
    logic        flush2;
    wb_t         wb;

    int     seed         = 32'h5843;
    string  test_name    = "reset";
    int     value_errors = 0;
    int     check_errors = 0;
    int     timeouts     = 0;
    // expected writes keyed by destination register
    int     issued_cnt [NREGS];
    int     seen_cnt [NREGS];
    xword_t pend_data [NREGS];
    xword_t ref_mem [`ISSUE_DMEM_WORDS];
    logic   exp_known;
    xword_t exp_data;

    issue_top dut (
        .clk    (clk),
        .rst    (rst),
        .slot1  (slot1),
        .slot2  (slot2),
        .stall1 (stall1),
        .stall2 (stall2),
        .flush2 (flush2),
        .wb     (wb)
    );

    always #10 clk = ~clk;

    // count every result seen on the bus
    always @(negedge clk) begin
        if (!rst && wb.valid) begin
            seen_cnt[wb.rd] <= seen_cnt[wb.rd] + 1;
        end
    end

    assign exp_known = issued_cnt[wb.rd] != seen_cnt[wb.rd];
    assign exp_data  = pend_data[wb.rd];

    wb_matches: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> exp_known && exp_data == wb.data)
    else begin
        value_errors++;
        $display("Mismatch %s: r%0d expected %h%s actual %h", test_name, $sampled(wb.rd),
                 $sampled(exp_data), $sampled(exp_known) ? "" : " (none outstanding)",
                 $sampled(wb.data));
    end

    flush_on_jump: assert property (@(negedge clk) disable iff (rst)
        flush2 == (slot1.valid && !stall1 && slot1.op_class == op_jump))
    else begin
        check_errors++;
        $display("%s: flush2 does not follow an issuing jump in slot 1", test_name);
    end

    function automatic xword_t rnd();
        return xword_t'($random(seed));
    endfunction

    function automatic xword_t ref_result(issue_slot_t s);
        case (s.op_class)
            op_mul:  return s.opa * s.opb;
            op_jump: return s.pc + 32'd4;
            op_load: return ref_mem[(s.opa / 4) % `ISSUE_DMEM_WORDS];
            default: begin
                case (s.fn)
                    fn_add:  return s.opa + s.opb;
                    fn_sub:  return s.opa - s.opb;
                    fn_and:  return s.opa & s.opb;
                    default: return s.opa | s.opb;
                endcase
            end
        endcase
    endfunction

    // a result on the bus this cycle no longer counts as outstanding
    function automatic logic outstanding(reg_addr_t r);
        int n;
        n = issued_cnt[r] - seen_cnt[r];
        if (wb.valid && wb.rd == r) begin
            n--;
        end
        return n > 0;
    endfunction

    function automatic logic any_outstanding();
        for (int r = 0; r < NREGS; r++) begin
            if (issued_cnt[r] != seen_cnt[r]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic issue_slot_t make_slot(op_class_t op, alu_fn_t fn, reg_addr_t rd,
                                              reg_addr_t rs1, reg_addr_t rs2,
                                              xword_t a, xword_t b);
        issue_slot_t s;
        s          = '0;
        s.valid    = 1'b1;
        s.op_class = op;
        s.fn       = fn;
        s.rd       = rd;
        s.rd_en    = op != op_store;
        s.rs1      = rs1;
        s.rs1_en   = op != op_jump;
        s.rs2      = rs2;
        s.rs2_en   = op == op_alu || op == op_mul || op == op_store;
        s.opa      = a;
        s.opb      = b;
        return s;
    endfunction

    task automatic record_issue(issue_slot_t s);
        logic hazard;
        hazard = (s.rs1_en && outstanding(s.rs1)) || (s.rs2_en && outstanding(s.rs2)) ||
                 (s.rd_en && outstanding(s.rd));
        assert (!hazard) else begin
            check_errors++;
            $display("%s: slot for r%0d issued before a register it uses was written back",
                     test_name, s.rd);
        end
        if (s.op_class == op_store) begin
            ref_mem[(s.opa / 4) % `ISSUE_DMEM_WORDS] = s.opb;
        end else if (s.rd_en) begin
            pend_data[s.rd] = ref_result(s);
            issued_cnt[s.rd]++;
        end
    endtask

    // present a pair and hold stalled slots until they issue
    task automatic drive_pair(issue_slot_t s1, issue_slot_t s2, logic [2:0] exp_dec);
        int   waited;
        logic first;
        logic go1;
        logic go2;
        waited = 0;
        first  = 1'b1;
        slot1  = s1;
        slot2  = s2;
        while ((s1.valid || s2.valid) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (first) begin
                assert ({stall1, stall2, flush2} == exp_dec) else begin
                    value_errors++;
                    $display("Mismatch %s: stall1 stall2 flush2 expected %b actual %b",
                             test_name, exp_dec, {stall1, stall2, flush2});
                end
                first = 1'b0;
            end
            go1 = s1.valid && !stall1;
            go2 = s2.valid && !stall2 && !flush2;
            if (go1) begin
                record_issue(s1);
                s1.valid = 1'b0;
            end
            if (go2) begin
                record_issue(s2);
                s2.valid = 1'b0;
            end else if (flush2) begin
                s2.valid = 1'b0;
            end
            @(posedge clk);
            #2;
            slot1 = s1;
            slot2 = s2;
            waited++;
        end
        if (s1.valid || s2.valid) begin
            timeouts++;
            $display("%s: timeout, a slot stayed stalled for %0d cycles", test_name, waited);
            slot1 = '0;
            slot2 = '0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (any_outstanding() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (any_outstanding()) begin
            timeouts++;
            $display("%s: timeout, results still missing from the writeback bus", test_name);
        end
    endtask

    task automatic idle_cycles(int n);
        slot1 = '0;
        slot2 = '0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        issue_slot_t s1;
        issue_slot_t s2;
        xword_t      a;
        xword_t      b;
        int          seen_before;
        clk   = 1'b0;
        rst   = 1'b1;
        slot1 = '0;
        slot2 = '0;
        for (int r = 0; r < NREGS; r++) begin
            issued_cnt[r] = 0;
            pend_data[r]  = '0;
        end
        for (int i = 0; i < `ISSUE_DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (wb.valid === 1'b0 && {stall1, stall2, flush2} === 3'b000) else begin
            check_errors++;
            $display("reset: writeback or stall outputs not idle after reset");
        end
        @(posedge clk);
        #2;

        test_name = "dual_alu";
        drive_pair(make_slot(op_alu, fn_add, 5'd1, 5'd21, 5'd22, rnd(), rnd()),
                   make_slot(op_alu, fn_sub, 5'd2, 5'd23, 5'd24, rnd(), rnd()), 3'b000);
        wait_drain();
        drive_pair(make_slot(op_alu, fn_and, 5'd3, 5'd21, 5'd22, rnd(), rnd()),
                   make_slot(op_alu, fn_or, 5'd4, 5'd23, 5'd24, rnd(), rnd()), 3'b000);
        wait_drain();

        // consumer carries the product as its operand
        test_name = "mul_raw";
        a = rnd();
        b = rnd();
        drive_pair(make_slot(op_mul, fn_add, 5'd5, 5'd25, 5'd26, a, b), '0, 3'b000);
        drive_pair(make_slot(op_alu, fn_add, 5'd6, 5'd5, 5'd27, a * b, rnd()), '0, 3'b100);
        wait_drain();

        test_name = "pair_raw";
        drive_pair(make_slot(op_alu, fn_add, 5'd7, 5'd28, 5'd29, rnd(), rnd()),
                   make_slot(op_alu, fn_sub, 5'd9, 5'd7, 5'd30, rnd(), rnd()), 3'b010);
        wait_drain();
        test_name = "pair_waw";
        drive_pair(make_slot(op_alu, fn_or, 5'd8, 5'd28, 5'd29, rnd(), rnd()),
                   make_slot(op_alu, fn_and, 5'd8, 5'd30, 5'd31, rnd(), rnd()), 3'b010);
        wait_drain();

        // 0x124 and 0x24 land on the same word
        test_name = "store_load";
        drive_pair(make_slot(op_store, fn_add, 5'd0, 5'd12, 5'd13, 32'h0000_0124, rnd()),
                   make_slot(op_load, fn_add, 5'd14, 5'd12, 5'd0, 32'h0000_0024, '0), 3'b010);
        wait_drain();
        test_name = "load_reset";
        drive_pair(make_slot(op_load, fn_add, 5'd15, 5'd12, 5'd0, 32'h0000_0040, '0), '0,
                   3'b000);
        wait_drain();

        // load and both products request in the same cycle
        test_name = "units_full";
        drive_pair(make_slot(op_mul, fn_add, 5'd16, 5'd1, 5'd2, rnd(), rnd()),
                   make_slot(op_mul, fn_add, 5'd17, 5'd3, 5'd4, rnd(), rnd()), 3'b000);
        idle_cycles(2);
        drive_pair(make_slot(op_load, fn_add, 5'd18, 5'd12, 5'd0, 32'h0000_0124, '0),
                   make_slot(op_alu, fn_add, 5'd19, 5'd20, 5'd21, rnd(), rnd()), 3'b010);
        wait_drain();

        test_name   = "jump_flush";
        s1          = make_slot(op_jump, fn_add, 5'd22, 5'd0, 5'd0, '0, '0);
        s1.pc       = 32'h0000_0100 + (rnd() & 32'h0000_0ffc);
        s2          = make_slot(op_alu, fn_add, 5'd23, 5'd24, 5'd25, rnd(), rnd());
        seen_before = seen_cnt[23];
        drive_pair(s1, s2, 3'b001);
        wait_drain();
        idle_cycles(4);
        assert (seen_cnt[23] == seen_before) else begin
            check_errors++;
            $display("%s: the flushed slot wrote r23 on the writeback bus", test_name);
        end

        idle_cycles(2);
        $display("errors: %0d mismatch, %0d protocol, %0d timeout",
                 value_errors, check_errors, timeouts);
        if (value_errors + check_errors + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
logic/issue_pkg.sv
logic/issue_scoreboard.sv
logic/int_unit.sv
logic/mem_unit.sv
logic/wb_arbiter.sv
logic/issue_top.sv
testbench/tb_issue_top.sv
